// File: design/crc_pkg.sv
// Ethernet FCS shared types
`default_nettype none

package crc_pkg;

    // One data word, also the width of the CRC register
    typedef logic [31:0] crc_word_t;

    // Every frame starts from an all-ones register
    localparam crc_word_t CRC_INIT = 32'hFFFF_FFFF;

    // Register contents after a good frame followed by its own FCS.
    // This is the non-reflected form of the usual CRC-32 magic number
    localparam crc_word_t CRC_RESIDUE = 32'hC704_DD7B;

    // Frame tracking in the decode stage
    typedef enum logic {
        IDLE,
        IN_FRAME
    } decode_state_t;

endpackage

`default_nettype wire

// File: design/crc_word_if.sv
// Stage to stage word channel
`timescale 1ns/1ps
`default_nettype none

interface crc_word_if import crc_pkg::*; ();

    // No handshake, sof and eof only mean something while valid is high
    logic      valid;
    logic      sof;
    logic      eof;
    crc_word_t data;

    modport src (
        output valid,
        output sof,
        output eof,
        output data
    );

    modport dst (
        input valid,
        input sof,
        input eof,
        input data
    );

endinterface

`default_nettype wire

// File: design/frame_decode.sv
// Frame boundary decode
`timescale 1ns/1ps
`default_nettype none

module frame_decode import crc_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            in_valid,
    input  wire            in_sof,
    input  wire            in_eof,
    input  wire crc_word_t in_data,
    crc_word_if.src        out
);

    decode_state_t state;
    decode_state_t state_next;
    logic          accept;
    crc_word_t     data_rev;

    // Byte 0 is sent first and each byte goes out LSB first.
    // Placing byte 0 reversed in the top byte gives the wire order MSB down
    function automatic crc_word_t reverse_bytes(crc_word_t w);
        crc_word_t r;
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < 8; i++) begin
                r[(3 - b) * 8 + (7 - i)] = w[b * 8 + i];
            end
        end
        return r;
    endfunction

    // A word is taken if it opens a frame or falls inside one
    assign accept = in_valid && (in_sof || state == IN_FRAME);

    assign data_rev = reverse_bytes(in_data);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // Stray words without sof are dropped here
                if (in_valid && in_sof) begin
                    state_next = in_eof ? IDLE : IN_FRAME;
                end
            end
            IN_FRAME: begin
                // A fresh sof restarts the frame, the state stays put
                if (in_valid && in_eof) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
            out.sof   <= 1'b0;
            out.eof   <= 1'b0;
        end else begin
            out.valid <= accept;
            out.sof   <= accept && in_sof;
            out.eof   <= accept && in_eof;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out.data <= data_rev;
        end
    end

endmodule

`default_nettype wire

// File: design/crc_execute.sv
// CRC word update stage
`timescale 1ns/1ps
`default_nettype none

module crc_execute import crc_pkg::*; #(
    parameter crc_word_t POLY = 32'h04C1_1DB7
) (
    input  wire     clk,
    input  wire     rst,
    crc_word_if.dst in,
    crc_word_if.src out
);

    crc_word_t crc_q;
    crc_word_t crc_seed;
    crc_word_t crc_next;

    // Word is already in wire order, MSB first, and the register is as
    // wide as the word, so the whole word can be XORed in before shifting
    function automatic crc_word_t fold_word(crc_word_t state, crc_word_t word);
        crc_word_t c;
        c = state ^ word;
        for (int i = 0; i < 32; i++) begin
            if (c[31]) begin
                c = (c << 1) ^ POLY;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    // Start of frame seeds the register, otherwise continue from the last word
    always_comb begin
        if (in.sof) begin
            crc_seed = CRC_INIT;
        end else begin
            crc_seed = crc_q;
        end
    end

    assign crc_next = fold_word(crc_seed, in.data);

    // Running state, only moves when a word arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            crc_q <= CRC_INIT;
        end else if (in.valid) begin
            crc_q <= crc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
            out.sof   <= 1'b0;
            out.eof   <= 1'b0;
        end else begin
            out.valid <= in.valid;
            out.sof   <= in.valid && in.sof;
            out.eof   <= in.valid && in.eof;
        end
    end

    // Result stage sees the state after this word
    always_ff @(posedge clk) begin
        if (in.valid) begin
            out.data <= crc_next;
        end
    end

endmodule

`default_nettype wire

// File: design/fcs_result.sv
// End of frame FCS result
`timescale 1ns/1ps
`default_nettype none

module fcs_result import crc_pkg::*; #(
    parameter crc_word_t RESIDUE = CRC_RESIDUE
) (
    input  wire       clk,
    input  wire       rst,
    crc_word_if.dst   in,
    output logic      crc_valid,
    output crc_word_t crc_value,
    output logic      fcs_ok
);

    logic      frame_end;
    crc_word_t state_rev;

    // Register is MSB first, the FCS goes on the wire reflected
    function automatic crc_word_t reverse_word(crc_word_t w);
        crc_word_t r;
        for (int i = 0; i < 32; i++) begin
            r[31 - i] = w[i];
        end
        return r;
    endfunction

    assign frame_end = in.valid && in.eof;
    assign state_rev = reverse_word(in.data);

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_valid <= 1'b0;
        end else begin
            crc_valid <= frame_end;
        end
    end

    // Value and check hold until the next frame ends
    always_ff @(posedge clk) begin
        if (rst) begin
            crc_value <= '0;
            fcs_ok    <= 1'b0;
        end else if (frame_end) begin
            crc_value <= ~state_rev;
            // With the FCS folded in, a clean frame leaves the fixed residue
            fcs_ok    <= (in.data == RESIDUE);
        end
    end

endmodule

`default_nettype wire

// File: design/eth_fcs_top.sv
// Ethernet FCS pipeline top
`timescale 1ns/1ps
`default_nettype none

module eth_fcs_top import crc_pkg::*; #(
    parameter crc_word_t POLY    = 32'h04C1_1DB7,
    parameter crc_word_t RESIDUE = CRC_RESIDUE
) (
    input  wire            clk,
    input  wire            rst,
    input  wire            in_valid,
    input  wire            in_sof,
    input  wire            in_eof,
    input  wire crc_word_t in_data,
    output logic           crc_valid,
    output crc_word_t      crc_value,
    output logic           fcs_ok
);

    // Decode to execute carries the reversed word
    crc_word_if dec_if ();

    // Execute to result carries the CRC state after each word
    crc_word_if exe_if ();

    frame_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_sof   (in_sof),
        .in_eof   (in_eof),
        .in_data  (in_data),
        .out      (dec_if.src)
    );

    crc_execute #(
        .POLY (POLY)
    ) u_execute (
        .clk (clk),
        .rst (rst),
        .in  (dec_if.dst),
        .out (exe_if.src)
    );

    fcs_result #(
        .RESIDUE (RESIDUE)
    ) u_result (
        .clk       (clk),
        .rst       (rst),
        .in        (exe_if.dst),
        .crc_valid (crc_valid),
        .crc_value (crc_value),
        .fcs_ok    (fcs_ok)
    );

endmodule

`default_nettype wire

// File: tb/eth_fcs_chk.sv
// FCS pipeline port checks
`timescale 1ns/1ps
`default_nettype none

module eth_fcs_chk (
    input wire clk,
    input wire rst,
    input wire in_valid,
    input wire in_sof,
    input wire in_eof,
    input wire crc_valid
);

    // A one-word frame is always taken and gives its result three edges later
    single_word_result: assert property (
        @(posedge clk) disable iff (rst)
        in_valid && in_sof && in_eof |-> ##3 crc_valid
    ) else $error("no crc_valid three cycles after a single-word frame");

    // Result strobe stays quiet while in reset and on the first cycle out of it
    quiet_in_reset: assert property (
        @(posedge clk) $past(rst) |-> !crc_valid
    ) else $error("crc_valid high during or right after reset");

    // Three register stages sit between the eof word and its result
    result_follows_eof: assert property (
        @(posedge clk) disable iff (rst) crc_valid |-> $past(in_valid && in_eof, 3)
    ) else $error("crc_valid without an eof word three cycles earlier");

endmodule

bind eth_fcs_top eth_fcs_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_sof    (in_sof),
    .in_eof    (in_eof),
    .crc_valid (crc_valid)
);

`default_nettype wire

// File: tb/eth_fcs_tb.sv
// Ethernet FCS testbench
`timescale 1ns/1ps
`default_nettype none

module eth_fcs_tb;

    localparam int MAX_WORDS = 17;

    // CRC of any frame that carries its own correct FCS at the end
    localparam logic [31:0] CRC_MAGIC = 32'h2144_DF1C;

    // Worst case input cycles per test, words plus idle gaps
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_CYCLES = 40 * (16 + 3);
    localparam int FCS_CYCLES = 10 * 2 * (MAX_WORDS + 3);
    localparam int STRAY_CYCLES = 8 * (4 + 16 + 3);
    localparam int B2B_CYCLES = 30 * 8;
    localparam int STIM_CYCLES = RESET_CYCLES + RANDOM_CYCLES + FCS_CYCLES
                               + STRAY_CYCLES + B2B_CYCLES;
    localparam int CYCLE_LIMIT = STIM_CYCLES + 100;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_sof;
    logic        in_eof;
    logic [31:0] in_data;
    logic        crc_valid;
    logic [31:0] crc_value;
    logic        fcs_ok;

    logic [31:0] rng_state = 32'd59;
    logic [31:0] frame_words [0:MAX_WORDS-1];
    logic [31:0] exp_crc [$];
    logic        exp_ok [$];
    logic [31:0] pop_crc;
    logic        pop_ok;

    int cycle_count = 0;
    int checks = 0;
    int errors = 0;
    int test_checks_start = 0;
    int test_errors_start = 0;

    eth_fcs_top UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_sof    (in_sof),
        .in_eof    (in_eof),
        .in_data   (in_data),
        .crc_valid (crc_valid),
        .crc_value (crc_value),
        .fcs_ok    (fcs_ok)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = next_random();
        return lo + int'(r % 32'(hi - lo + 1));
    endfunction

    // Reflected CRC-32, one byte at a time starting from byte 0 of each word
    function automatic logic [31:0] model_crc(input int n_words);
        logic [31:0] c;
        logic [7:0]  byte_val;
        c = 32'hFFFF_FFFF;
        for (int w = 0; w < n_words; w++) begin
            for (int b = 0; b < 4; b++) begin
                byte_val = 8'(frame_words[w] >> (8 * b));
                c = c ^ {24'h0, byte_val};
                for (int k = 0; k < 8; k++) begin
                    if (c[0]) begin
                        c = (c >> 1) ^ 32'hEDB8_8320;
                    end else begin
                        c = c >> 1;
                    end
                end
            end
        end
        return ~c;
    endfunction

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("error at %0t: %s expected %h got %h", $time, sig, expected, actual);
            errors++;
        end
    endtask

    task automatic drive_word(input logic valid, input logic sof, input logic eof,
                              input logic [31:0] data);
        @(posedge clk);
        in_valid <= valid;
        in_sof   <= sof;
        in_eof   <= eof;
        in_data  <= data;
    endtask

    task automatic drive_idle();
        drive_word(1'b0, 1'b0, 1'b0, next_random());
    endtask

    task automatic fill_random(input int n_words);
        for (int i = 0; i < n_words; i++) begin
            frame_words[i] = next_random();
        end
    endtask

    task automatic send_frame(input int n_words, input int gap);
        logic [31:0] expected;
        expected = model_crc(n_words);
        exp_crc.push_back(expected);
        exp_ok.push_back(expected == CRC_MAGIC);
        for (int i = 0; i < n_words; i++) begin
            drive_word(1'b1, i == 0, i == n_words - 1, frame_words[i]);
        end
        for (int g = 0; g < gap; g++) begin
            drive_idle();
        end
    endtask

    task automatic wait_drain();
        drive_idle();
        while (exp_crc.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic mark_test_start();
        test_checks_start = checks;
        test_errors_start = errors;
    endtask

    task automatic print_test_result(input string name);
        $display("test %s: %0d checks, %0d errors", name,
                 checks - test_checks_start, errors - test_errors_start);
    endtask

    // Results are read mid-cycle, away from the edge where they change
    always @(negedge clk) begin
        if (!rst && crc_valid) begin
            checks++;
            assert (exp_crc.size() != 0) else begin
                $display("crc_valid at %0t with no frame outstanding", $time);
                errors++;
            end
            if (exp_crc.size() != 0) begin
                pop_crc = exp_crc.pop_front();
                pop_ok  = exp_ok.pop_front();
                check_value("crc_value", pop_crc, crc_value);
                check_value("fcs_ok", {31'h0, pop_ok}, {31'h0, fcs_ok});
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: results still missing after %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int len;
        int bit_idx;
        rst      <= 1'b1;
        in_valid <= 1'b0;
        in_sof   <= 1'b0;
        in_eof   <= 1'b0;
        in_data  <= 32'h0;

        mark_test_start();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("crc_valid", 32'h0, {31'h0, crc_valid});
        check_value("fcs_ok", 32'h0, {31'h0, fcs_ok});
        check_value("crc_value", 32'h0, crc_value);
        print_test_result("after reset");

        mark_test_start();
        for (int f = 0; f < 40; f++) begin
            len = rand_range(1, 16);
            fill_random(len);
            send_frame(len, rand_range(0, 3));
        end
        wait_drain();
        print_test_result("random frames");

        // Good frame first, then the same frame with one bit flipped
        mark_test_start();
        for (int f = 0; f < 10; f++) begin
            len = rand_range(1, 16);
            fill_random(len);
            frame_words[len] = model_crc(len);
            send_frame(len + 1, rand_range(0, 3));
            bit_idx = rand_range(0, (len + 1) * 32 - 1);
            frame_words[bit_idx / 32] = frame_words[bit_idx / 32] ^ (32'h1 << (bit_idx % 32));
            send_frame(len + 1, rand_range(0, 3));
        end
        wait_drain();
        print_test_result("frames with fcs");

        mark_test_start();
        for (int f = 0; f < 8; f++) begin
            len = rand_range(1, 4);
            for (int s = 0; s < len; s++) begin
                drive_word(1'b1, 1'b0, rand_range(0, 1) == 1, next_random());
            end
            len = rand_range(1, 16);
            fill_random(len);
            send_frame(len, rand_range(0, 3));
        end
        wait_drain();
        print_test_result("stray words");

        // Single word frames mixed with longer ones, no idle cycle between
        mark_test_start();
        for (int f = 0; f < 30; f++) begin
            if (f % 3 == 0) begin
                len = 1;
            end else begin
                len = rand_range(1, 8);
            end
            fill_random(len);
            send_frame(len, 0);
        end
        wait_drain();
        print_test_result("back to back frames");

        $display("checks passed: %0d, failed: %0d", checks - errors, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
design/crc_pkg.sv
design/crc_word_if.sv
design/frame_decode.sv
design/crc_execute.sv
design/fcs_result.sv
design/eth_fcs_top.sv
tb/eth_fcs_chk.sv
tb/eth_fcs_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the Ethernet FCS testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module eth_fcs_tb \
    -f flist.f \
    -o eth_fcs_sim

./obj_dir/eth_fcs_sim > sim.log 2>&1
cat sim.log

if grep -q -x -F '** PASS **' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
